// File: files.f
source/icachePkg.sv
source/icacheReq.sv
source/icacheWay.sv
source/icacheLru.sv
source/icacheTop.sv
verif/icacheTop_asserts.sv
verif/icacheTb.sv

// File: run.sh
#!/bin/sh
# builds the cache testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module icacheTb \
  -o icacheSim && ./obj_dir/icacheSim > sim.log 2>&1
grep -q "Test completed successfully" sim.log && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }

// File: source/icacheLru.sv
`timescale 1ns/100ps

module icacheLru (
  input  logic               clk,
  input  logic               rstN,
  input  icachePkg::setIdxT  regIdx,
  input  logic               regRead,
  input  logic               regInsert,
  input  logic               initEn,
  input  icachePkg::wayMaskT tagMatch,
  input  icachePkg::instrT   wayInstr0,
  input  icachePkg::instrT   wayInstr1,
  input  icachePkg::instrT   wayInstr2,
  input  icachePkg::instrT   wayInstr3,
  output icachePkg::wayMaskT fillWe,
  output logic               hit,
  output icachePkg::instrT   instr
);

  localparam icachePkg::lruPosT oldestPos = icachePkg::lruPosT'(icachePkg::numWays - 1);

  icachePkg::lruPosT  pos [icachePkg::numSets][icachePkg::numWays];
  icachePkg::lruPosT  curPos [icachePkg::numWays];
  icachePkg::lruPosT  newPos [icachePkg::numWays];
  icachePkg::instrT   wayInstr [icachePkg::numWays];
  icachePkg::wayMaskT selWay;
  icachePkg::lruPosT  selPos;
  logic               found;

  assign wayInstr[0] = wayInstr0;
  assign wayInstr[1] = wayInstr1;
  assign wayInstr[2] = wayInstr2;
  assign wayInstr[3] = wayInstr3;

  // a read takes the lowest matching way, an insert takes the oldest way
  always_comb
  begin
    selWay = '0;
    selPos = '0;
    found  = 1'b0;
    instr  = '0;
    for (int w = 0; w < icachePkg::numWays; w++)
    begin
      curPos[w] = pos[regIdx][w];
      if (!found && ((regRead && tagMatch[w]) || (regInsert && curPos[w] == oldestPos)))
      begin
        selWay[w] = 1'b1;
        selPos    = curPos[w];
        found     = 1'b1;
        if (regRead)
          instr = wayInstr[w];
      end
    end
  end

  always_comb
  begin
    for (int w = 0; w < icachePkg::numWays; w++)
    begin
      if (selWay[w])
        newPos[w] = '0;
      else if (curPos[w] < selPos)
        newPos[w] = curPos[w] + 1'b1;
      else
        newPos[w] = curPos[w];
    end
  end

  assign hit    = regRead && found;
  assign fillWe = selWay & {icachePkg::numWays{regInsert}};

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      for (int s = 0; s < icachePkg::numSets; s++)
        for (int w = 0; w < icachePkg::numWays; w++)
          pos[s][w] <= icachePkg::lruPosT'(w);
    end
    else if (initEn)
    begin
      for (int w = 0; w < icachePkg::numWays; w++)
        pos[regIdx][w] <= icachePkg::lruPosT'(w);
    end
    else if (found)
    begin
      // misses leave the order alone
      for (int w = 0; w < icachePkg::numWays; w++)
        pos[regIdx][w] <= newPos[w];
    end
  end

endmodule

// File: source/icachePkg.sv
package icachePkg;

  // cache geometry
  localparam int numWays      = 4;
  localparam int numSets      = 64;
  localparam int wordsPerLine = 16;

  // address split, word select sits at bits 5 to 2
  localparam int indexBits  = 6;
  localparam int offsetBits = 4;
  localparam int tagBits    = 26;
  localparam int lineBits   = 512;

  typedef logic [31:0] fetchAddrT;

  typedef logic [tagBits-1:0] tagT;

  typedef logic [indexBits-1:0] setIdxT;

  typedef logic [offsetBits-1:0] wordSelT;

  // word 0 sits in the low bits of the line
  typedef logic [lineBits-1:0] lineT;

  typedef logic [31:0] instrT;

  // 0 is the most recent way and 3 the least recent
  typedef logic [1:0] lruPosT;

  typedef logic [numWays-1:0] wayMaskT;

  typedef enum logic [1:0] {
    initClear,
    initRun,
    initDone
  } initStateT;

endpackage

// File: source/icacheReq.sv
`timescale 1ns/100ps

module icacheReq (
  input  logic                 clk,
  input  logic                 rstN,
  input  icachePkg::fetchAddrT addr,
  input  logic                 readEn,
  input  logic                 insert,
  input  icachePkg::lineT      fillLine,
  output logic                 ready,
  output icachePkg::setIdxT    rdIdx,
  output icachePkg::setIdxT    regIdx,
  output icachePkg::tagT       regTag,
  output icachePkg::wordSelT   regWord,
  output logic                 regRead,
  output logic                 regInsert,
  output icachePkg::lineT      regLine,
  output logic                 initEn
);

  icachePkg::initStateT state;
  icachePkg::setIdxT    initCount;
  icachePkg::setIdxT    idxQ;
  logic                 readAcc;
  logic                 insertAcc;

  assign readAcc   = ready && readEn;
  assign insertAcc = ready && insert;

  // the set index goes straight to the RAM read ports
  assign rdIdx = addr[icachePkg::offsetBits + 2 +: icachePkg::indexBits];

  assign initEn = (state == icachePkg::initRun);
  assign regIdx = initEn ? initCount : idxQ;

  // sweep over all sets once after reset
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      state     <= icachePkg::initClear;
      initCount <= '0;
    end
    else
    begin
      case (state)
        icachePkg::initClear:
        begin
          initCount <= '0;
          state     <= icachePkg::initRun;
        end
        icachePkg::initRun:
        begin
          initCount <= initCount + 1'b1;
          if (initCount == icachePkg::setIdxT'(icachePkg::numSets - 1))
            state <= icachePkg::initDone;
        end
        default: state <= icachePkg::initDone;
      endcase
    end
  end

  // the cycle after an insert is held off while the way is written
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      ready     <= 1'b0;
      regRead   <= 1'b0;
      regInsert <= 1'b0;
    end
    else
    begin
      ready     <= (state == icachePkg::initDone) && !insertAcc;
      regRead   <= readAcc;
      regInsert <= insertAcc;
    end
  end

  // the tag covers address bits 31 to 6, the set index included
  always_ff @(posedge clk)
  begin
    if (readAcc || insertAcc)
    begin
      idxQ    <= rdIdx;
      regTag  <= addr[icachePkg::offsetBits + 2 +: icachePkg::tagBits];
      regWord <= addr[2 +: icachePkg::offsetBits];
      regLine <= fillLine;
    end
  end

endmodule

// File: source/icacheTop.sv
`timescale 1ns/100ps

module icacheTop (
  input  logic                 clk,
  input  logic                 rstN,
  input  icachePkg::fetchAddrT addr,
  input  logic                 readEn,
  input  logic                 insert,
  input  icachePkg::lineT      fillLine,
  output logic                 ready,
  output logic                 hit,
  output icachePkg::instrT     instr
);

  icachePkg::setIdxT  rdIdx;
  icachePkg::setIdxT  regIdx;
  icachePkg::tagT     regTag;
  icachePkg::wordSelT regWord;
  icachePkg::lineT    regLine;
  logic               regRead;
  logic               regInsert;
  logic               initEn;
  icachePkg::wayMaskT fillWe;
  icachePkg::wayMaskT tagMatch;
  icachePkg::instrT   wayInstr [icachePkg::numWays];

  icacheReq i_req (
    .clk(clk), .rstN(rstN), .addr(addr), .readEn(readEn), .insert(insert),
    .fillLine(fillLine), .ready(ready), .rdIdx(rdIdx), .regIdx(regIdx),
    .regTag(regTag), .regWord(regWord), .regRead(regRead),
    .regInsert(regInsert), .regLine(regLine), .initEn(initEn)
  );

  for (genvar w = 0; w < icachePkg::numWays; w++)
  begin : gWay
    icacheWay i_way (
      .clk(clk), .rstN(rstN), .rdIdx(rdIdx), .regIdx(regIdx), .regTag(regTag),
      .regWord(regWord), .regLine(regLine), .fillWe(fillWe[w]), .initEn(initEn),
      .tagMatch(tagMatch[w]), .wayInstr(wayInstr[w])
    );
  end

  icacheLru i_lru (
    .clk(clk), .rstN(rstN), .regIdx(regIdx), .regRead(regRead),
    .regInsert(regInsert), .initEn(initEn), .tagMatch(tagMatch),
    .wayInstr0(wayInstr[0]), .wayInstr1(wayInstr[1]),
    .wayInstr2(wayInstr[2]), .wayInstr3(wayInstr[3]),
    .fillWe(fillWe), .hit(hit), .instr(instr)
  );

endmodule

// File: source/icacheWay.sv
`timescale 1ns/100ps

module icacheWay (
  input  logic               clk,
  input  logic               rstN,
  input  icachePkg::setIdxT  rdIdx,
  input  icachePkg::setIdxT  regIdx,
  input  icachePkg::tagT     regTag,
  input  icachePkg::wordSelT regWord,
  input  icachePkg::lineT    regLine,
  input  logic               fillWe,
  input  logic               initEn,
  output logic               tagMatch,
  output icachePkg::instrT   wayInstr
);

  localparam int instrBits = $bits(icachePkg::instrT);

  icachePkg::lineT                lineRam [icachePkg::numSets];
  icachePkg::tagT                 tagRam  [icachePkg::numSets];
  logic [icachePkg::numSets-1:0] valid;
  icachePkg::lineT                lineQ;
  icachePkg::tagT                 tagQ;

  // both RAMs are read every cycle, the result is used only in stage 2
  always_ff @(posedge clk)
  begin
    lineQ <= lineRam[rdIdx];
    if (fillWe)
      lineRam[regIdx] <= regLine;
  end

  always_ff @(posedge clk)
  begin
    tagQ <= tagRam[rdIdx];
    if (fillWe)
      tagRam[regIdx] <= regTag;
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
      valid <= '0;
    else if (initEn)
      valid[regIdx] <= 1'b0;
    else if (fillWe)
      valid[regIdx] <= 1'b1;
  end

  assign tagMatch = valid[regIdx] && (tagQ == regTag);

  always_comb
  begin
    wayInstr = '0;
    for (int i = 0; i < icachePkg::wordsPerLine; i++)
    begin
      if (regWord == icachePkg::wordSelT'(i))
        wayInstr = lineQ[i*instrBits +: instrBits];
    end
  end

endmodule

// File: verif/icacheTb.sv
`timescale 1ns/100ps

module icacheTb;

  localparam int maxWait  = 100;
  localparam int sweepLen = 66;
  localparam int randOps  = 3000;

  logic                 clk;
  logic                 rstN;
  icachePkg::fetchAddrT addr;
  logic                 readEn;
  logic                 insert;
  icachePkg::lineT      fillLine;
  logic                 ready;
  logic                 hit;
  icachePkg::instrT     instr;
  logic                 gotHit;

  // reference model of every set and way
  icachePkg::tagT    mTag   [icachePkg::numSets][icachePkg::numWays];
  logic              mValid [icachePkg::numSets][icachePkg::numWays];
  icachePkg::lruPosT mPos   [icachePkg::numSets][icachePkg::numWays];
  icachePkg::lineT   mLine  [icachePkg::numSets][icachePkg::numWays];

  icacheTop i_icacheTop (
    .clk(clk), .rstN(rstN), .addr(addr), .readEn(readEn), .insert(insert),
    .fillLine(fillLine), .ready(ready), .hit(hit), .instr(instr)
  );

  bind icacheTop icacheTop_asserts i_asserts (
    .clk(clk), .rstN(rstN), .readEn(readEn), .insert(insert), .ready(ready), .hit(hit)
  );

  always #5 clk = ~clk;

  task automatic stopRun(string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic checkInstr(icachePkg::instrT got, icachePkg::instrT exp);
    if (got !== exp)
      stopRun($sformatf("ERR instr got %h expected %h", got, exp));
  endtask

  task automatic checkHit(logic got, logic exp);
    if (got !== exp)
      stopRun($sformatf("ERR hit got %h expected %h", got, exp));
  endtask

  task automatic checkReady(logic got, logic exp);
    if (got !== exp)
      stopRun($sformatf("ERR ready got %h expected %h", got, exp));
  endtask

  task automatic waitReady();
    int waited;
    waited = 0;
    while (!ready)
    begin
      @(negedge clk);
      waited++;
      if (waited > maxWait)
        stopRun("timed out waiting for ready");
    end
  endtask

  // the low six bits of a tag are its set index
  function automatic icachePkg::tagT makeTag(int s, int t);
    logic [19:0] upper;
    upper = 20'(32'h9e37 * (t + 1) + 32'h51 * s);
    return {upper, icachePkg::setIdxT'(s * 21 + 5)};
  endfunction

  function automatic int findWay(icachePkg::setIdxT idx, icachePkg::tagT tag);
    int way;
    way = -1;
    for (int w = 0; w < icachePkg::numWays; w++)
      if (mValid[idx][w] && mTag[idx][w] == tag)
        way = w;
    return way;
  endfunction

  // the used way becomes most recent and the ways that were more recent age by one
  function automatic void touchWay(icachePkg::setIdxT idx, int way);
    icachePkg::lruPosT old;
    old = mPos[idx][way];
    for (int w = 0; w < icachePkg::numWays; w++)
    begin
      if (w == way)
        mPos[idx][w] = '0;
      else if (mPos[idx][w] < old)
        mPos[idx][w] = mPos[idx][w] + 1'b1;
    end
  endfunction

  task automatic doRead(icachePkg::tagT tag, icachePkg::wordSelT word, output logic gotHit);
    icachePkg::setIdxT idx;
    icachePkg::instrT  expInstr;
    int                way;
    idx      = tag[icachePkg::indexBits-1:0];
    way      = findWay(idx, tag);
    expInstr = '0;
    if (way >= 0)
      expInstr = mLine[idx][way][int'(word)*32 +: 32];
    waitReady();
    addr   = {tag, word, 2'b00};
    readEn = 1'b1;
    @(negedge clk);
    readEn = 1'b0;
    checkHit(hit, way >= 0);
    checkInstr(instr, expInstr);
    if (way >= 0)
      touchWay(idx, way);
    gotHit = hit;
  endtask

  task automatic doInsert(icachePkg::tagT tag);
    icachePkg::setIdxT idx;
    icachePkg::lineT   line;
    int                way;
    idx = tag[icachePkg::indexBits-1:0];
    way = 0;
    for (int i = 0; i < icachePkg::wordsPerLine; i++)
      line[i*32 +: 32] = $urandom;
    waitReady();
    addr     = {tag, 6'h0};
    fillLine = line;
    insert   = 1'b1;
    @(negedge clk);
    insert = 1'b0;
    // the victim way is written during this cycle
    checkReady(ready, 1'b0);
    checkHit(hit, 1'b0);
    for (int w = 0; w < icachePkg::numWays; w++)
      if (mPos[idx][w] == 2'd3)
        way = w;
    mTag[idx][way]   = tag;
    mValid[idx][way] = 1'b1;
    mLine[idx][way]  = line;
    touchWay(idx, way);
  endtask

  initial
  begin
    icachePkg::tagT randTag;
    clk      = 1'b0;
    rstN     = 1'b0;
    addr     = '0;
    readEn   = 1'b0;
    insert   = 1'b0;
    fillLine = '0;
    void'($urandom(90573));
    for (int s = 0; s < icachePkg::numSets; s++)
      for (int w = 0; w < icachePkg::numWays; w++)
      begin
        mValid[s][w] = 1'b0;
        mPos[s][w]   = icachePkg::lruPosT'(w);
      end
    for (int c = 0; c < 5; c++)
    begin
      @(negedge clk);
      checkReady(ready, 1'b0);
    end
    rstN = 1'b1;
    // one clear cycle, 64 sweep cycles and one settling cycle
    for (int c = 0; c < sweepLen; c++)
    begin
      checkReady(ready, 1'b0);
      @(negedge clk);
    end
    checkReady(ready, 1'b1);

    for (int i = 0; i < 12; i++)
      doRead(makeTag(i % 3, $urandom % 6), icachePkg::wordSelT'($urandom % 16), gotHit);

    doInsert(makeTag(0, 0));
    for (int w = 0; w < icachePkg::wordsPerLine; w++)
    begin
      doRead(makeTag(0, 0), icachePkg::wordSelT'(w), gotHit);
      checkHit(gotHit, 1'b1);
    end

    // a fifth tag in set 0 pushes out the first one
    for (int t = 1; t < 5; t++)
      doInsert(makeTag(0, t));
    doRead(makeTag(0, 0), 4'h3, gotHit);
    checkHit(gotHit, 1'b0);
    for (int t = 1; t < 5; t++)
    begin
      doRead(makeTag(0, t), 4'h7, gotHit);
      checkHit(gotHit, 1'b1);
    end

    // refreshing the oldest way of set 1 moves the eviction to the next oldest
    for (int t = 0; t < 4; t++)
      doInsert(makeTag(1, t));
    doRead(makeTag(1, 0), 4'h0, gotHit);
    doInsert(makeTag(1, 4));
    doRead(makeTag(1, 0), 4'hf, gotHit);
    checkHit(gotHit, 1'b1);
    doRead(makeTag(1, 1), 4'hf, gotHit);
    checkHit(gotHit, 1'b0);

    for (int i = 0; i < randOps; i++)
    begin
      randTag = makeTag($urandom % 3, $urandom % 6);
      if (($urandom % 4 == 0) && findWay(randTag[icachePkg::indexBits-1:0], randTag) < 0)
        doInsert(randTag);
      else
        doRead(randTag, icachePkg::wordSelT'($urandom % 16), gotHit);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: verif/icacheTop_asserts.sv
`timescale 1ns/100ps

module icacheTop_asserts (
  input logic clk,
  input logic rstN,
  input logic readEn,
  input logic insert,
  input logic ready,
  input logic hit
);

  logic readAcc;
  logic insertAcc;

  assign readAcc   = ready && readEn;
  assign insertAcc = ready && insert;

  oneOpAtATime: assert property (@(posedge clk) disable iff (!rstN) !(readAcc && insertAcc))
    else $error("read and insert accepted in the same cycle");

  // a hit only ever answers the read taken one cycle earlier
  hitAfterRead: assert property (@(posedge clk) disable iff (!rstN) hit |-> $past(readAcc))
    else $error("hit without a read accepted in the previous cycle");

  holdAfterInsert: assert property (@(posedge clk) disable iff (!rstN) insertAcc |=> !ready)
    else $error("ready high in the cycle after an insert");

endmodule
